// ==== design/rv_bus_arbiter.sv ====
`timescale 1ns/1ps

module rv_bus_arbiter (
    input  logic          i_clk,
    input  logic          i_arst_n,
    input  logic          i_f_req,
    input  logic          i_f_we,
    input  rv_pkg::pc_t   i_f_addr,
    input  rv_pkg::word_t i_f_wdata,
    output logic          o_f_ack,
    output rv_pkg::word_t o_f_rdata,
    input  logic          i_d_req,
    input  logic          i_d_we,
    input  rv_pkg::pc_t   i_d_addr,
    input  rv_pkg::word_t i_d_wdata,
    output logic          o_d_ack,
    output rv_pkg::word_t o_d_rdata,
    output logic          o_m_req,
    output logic          o_m_we,
    output rv_pkg::pc_t   o_m_addr,
    output rv_pkg::word_t o_m_wdata,
    input  logic          i_m_ack,
    input  rv_pkg::word_t i_m_rdata
);
    typedef enum logic [1:0] {IDLE, GRANT_F, GRANT_D} state_e;

    state_e state;
    logic   gnt_f;
    logic   gnt_d;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:
                    if (i_d_req)
                        state <= GRANT_D;    // lsu first
                    else if (i_f_req)
                        state <= GRANT_F;
                GRANT_F:
                    if (!i_f_req && !i_m_ack)
                        state <= IDLE;
                GRANT_D:
                    if (!i_d_req && !i_m_ack)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign gnt_f = (state == GRANT_F);
    assign gnt_d = (state == GRANT_D);

    assign o_m_req   = (gnt_f && i_f_req) || (gnt_d && i_d_req);
    assign o_m_we    = gnt_d ? i_d_we : i_f_we;
    assign o_m_addr  = gnt_d ? i_d_addr : i_f_addr;
    assign o_m_wdata = gnt_d ? i_d_wdata : i_f_wdata;

    assign o_f_ack   = gnt_f && i_m_ack;
    assign o_d_ack   = gnt_d && i_m_ack;
    assign o_f_rdata = i_m_rdata;
    assign o_d_rdata = i_m_rdata;

endmodule

// ==== design/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
    parameter int            MEM_DEPTH = 256,
    parameter rv_pkg::word_t RESET_PC  = '0
) (
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic             i_run,
    input  logic             i_ld_we,
    input  rv_pkg::pc_t      i_ld_addr,
    input  rv_pkg::word_t    i_ld_data,
    output logic             o_wb_valid,
    output rv_pkg::reg_idx_t o_wb_rd,
    output rv_pkg::word_t    o_wb_data
);
    import rv_pkg::*;

    logic     stall;
    logic     flush;
    pc_t      redirect_pc;

    logic     f_req;
    logic     f_ack;
    pc_t      f_addr;
    word_t    f_rdata;
    logic     f_valid;
    word_t    f_instr;
    pc_t      f_pc;
    pc_t      f_pc_p4;

    reg_idx_t d_rs1;
    reg_idx_t d_rs2;
    reg_idx_t d_rd;
    pc_t      d_pc;
    pc_t      d_pc_p4;
    imm_t     d_imm;
    logic     d_reg_write;
    logic     d_mem_read;
    logic     d_mem_write;
    res_src_e d_res_src;
    logic     d_jump;
    logic     d_branch;
    logic     d_alu_src;
    logic     d_pc_rel;
    logic [2:0] d_funct3;
    alu_op_e  d_alu_ctrl;

    logic     lsu_start;
    logic     lsu_we;
    pc_t      lsu_addr;
    word_t    lsu_wdata;
    logic     lsu_done;
    word_t    lsu_rdata;

    logic     l_req;
    logic     l_we;
    pc_t      l_addr;
    word_t    l_wdata;
    logic     l_ack;
    word_t    l_rdata;

    logic     m_req;
    logic     m_we;
    pc_t      m_addr;
    word_t    m_wdata;
    logic     m_ack;
    word_t    m_rdata;

    rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_run(i_run),
        .i_stall(stall), .i_flush(flush), .i_redirect_pc(redirect_pc),
        .o_bus_req(f_req), .i_bus_ack(f_ack), .o_bus_addr(f_addr),
        .i_bus_rdata(f_rdata), .o_instr_valid(f_valid), .o_instr(f_instr),
        .o_pc(f_pc), .o_pc_p4(f_pc_p4)
    );

    rv_decode u_decode (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_stall(stall), .i_flush(flush),
        .i_instr_valid(f_valid), .i_instr(f_instr), .i_pc(f_pc), .i_pc_p4(f_pc_p4),
        .o_rs1(d_rs1), .o_rs2(d_rs2), .o_rd(d_rd), .o_pc(d_pc), .o_pc_p4(d_pc_p4),
        .o_imm(d_imm), .o_reg_write(d_reg_write), .o_mem_read(d_mem_read),
        .o_mem_write(d_mem_write), .o_res_src(d_res_src), .o_jump(d_jump),
        .o_branch(d_branch), .o_alu_src(d_alu_src), .o_pc_rel(d_pc_rel),
        .o_funct3(d_funct3), .o_alu_ctrl(d_alu_ctrl)
    );

    rv_execute u_execute (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_rs1(d_rs1), .i_rs2(d_rs2), .i_rd(d_rd), .i_pc(d_pc), .i_pc_p4(d_pc_p4),
        .i_imm(d_imm), .i_reg_write(d_reg_write), .i_mem_read(d_mem_read),
        .i_mem_write(d_mem_write), .i_res_src(d_res_src), .i_jump(d_jump),
        .i_branch(d_branch), .i_alu_src(d_alu_src), .i_pc_rel(d_pc_rel),
        .i_funct3(d_funct3), .i_alu_ctrl(d_alu_ctrl),
        .o_stall(stall), .o_flush(flush), .o_redirect_pc(redirect_pc),
        .o_lsu_start(lsu_start), .o_lsu_we(lsu_we), .o_lsu_addr(lsu_addr),
        .o_lsu_wdata(lsu_wdata), .i_lsu_done(lsu_done), .i_lsu_rdata(lsu_rdata),
        .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data)
    );

    rv_lsu u_lsu (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_start(lsu_start), .i_we(lsu_we),
        .i_addr(lsu_addr), .i_wdata(lsu_wdata), .o_done(lsu_done), .o_rdata(lsu_rdata),
        .o_bus_req(l_req), .o_bus_we(l_we), .o_bus_addr(l_addr),
        .o_bus_wdata(l_wdata), .i_bus_ack(l_ack), .i_bus_rdata(l_rdata)
    );

    rv_bus_arbiter u_arbiter (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_f_req(f_req), .i_f_we(1'b0), .i_f_addr(f_addr), .i_f_wdata('0),
        .o_f_ack(f_ack), .o_f_rdata(f_rdata),
        .i_d_req(l_req), .i_d_we(l_we), .i_d_addr(l_addr), .i_d_wdata(l_wdata),
        .o_d_ack(l_ack), .o_d_rdata(l_rdata),
        .o_m_req(m_req), .o_m_we(m_we), .o_m_addr(m_addr), .o_m_wdata(m_wdata),
        .i_m_ack(m_ack), .i_m_rdata(m_rdata)
    );

    rv_ram #(.MEM_DEPTH(MEM_DEPTH)) u_ram (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_req(m_req), .i_we(m_we), .i_addr(m_addr), .i_wdata(m_wdata),
        .o_ack(m_ack), .o_rdata(m_rdata),
        .i_ld_we(i_ld_we), .i_ld_addr(i_ld_addr), .i_ld_data(i_ld_data)
    );

endmodule

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic             i_stall,
    input  logic             i_flush,
    input  logic             i_instr_valid,
    input  rv_pkg::word_t    i_instr,
    input  rv_pkg::pc_t      i_pc,
    input  rv_pkg::pc_t      i_pc_p4,
    output rv_pkg::reg_idx_t o_rs1,
    output rv_pkg::reg_idx_t o_rs2,
    output rv_pkg::reg_idx_t o_rd,
    output rv_pkg::pc_t      o_pc,
    output rv_pkg::pc_t      o_pc_p4,
    output rv_pkg::imm_t     o_imm,
    output logic             o_reg_write,
    output logic             o_mem_read,
    output logic             o_mem_write,
    output rv_pkg::res_src_e o_res_src,
    output logic             o_jump,
    output logic             o_branch,
    output logic             o_alu_src,
    output logic             o_pc_rel,
    output logic [2:0]       o_funct3,
    output rv_pkg::alu_op_e  o_alu_ctrl
);
    import rv_pkg::*;

    word_t      instr;
    pc_t        pc;
    pc_t        pc_p4;
    logic [6:0] op;
    logic [2:0] funct3;

    // no strobe loads a bubble, so each instruction executes once
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            instr <= '0;
        else if (i_flush)
            instr <= '0;
        else if (!i_stall)
            instr <= i_instr_valid ? i_instr : '0;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_instr_valid && !i_stall)
        begin
            pc    <= i_pc;
            pc_p4 <= i_pc_p4;
        end
    end

    assign op     = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb
    begin
        case (op)
            OP_STORE:
                o_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            OP_BRANCH:
                o_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            OP_JAL:
                o_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            OP_LUI, OP_AUIPC:
                o_imm = {instr[31:12], 12'b0};
            default:
                o_imm = {{21{instr[31]}}, instr[30:20]};    // I type
        endcase
    end

    always_comb
    begin
        if ((op == OP_REG) || (op == OP_IMM))
        begin
            case (funct3)
                3'b000:  o_alu_ctrl = ((op == OP_REG) && instr[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  o_alu_ctrl = ALU_SHL;
                3'b010:  o_alu_ctrl = ALU_SLT;
                3'b011:  o_alu_ctrl = ALU_SLT;
                3'b100:  o_alu_ctrl = ALU_XOR;
                3'b101:  o_alu_ctrl = ALU_SHR;    // logical only
                3'b110:  o_alu_ctrl = ALU_OR;
                default: o_alu_ctrl = ALU_AND;
            endcase
        end
        else if (op == OP_BRANCH)
            o_alu_ctrl = ALU_SUB;
        else
            o_alu_ctrl = ALU_ADD;    // address, target and upper imm
    end

    always_comb
    begin
        case (op)
            OP_LOAD:         o_res_src = RES_MEM;
            OP_JAL, OP_JALR: o_res_src = RES_PC4;
            default:         o_res_src = RES_ALU;
        endcase
    end

    assign o_reg_write = (op == OP_REG) || (op == OP_LOAD) || (op == OP_IMM) ||
                         (op == OP_JALR) || (op == OP_JAL) || (op == OP_AUIPC) ||
                         (op == OP_LUI);
    assign o_mem_read  = (op == OP_LOAD);
    assign o_mem_write = (op == OP_STORE);
    assign o_branch    = (op == OP_BRANCH);
    assign o_jump      = (op == OP_JAL) || (op == OP_JALR);
    assign o_alu_src   = !((op == OP_REG) || (op == OP_BRANCH));
    assign o_pc_rel    = (op == OP_AUIPC) || (op == OP_JAL);

    assign o_rs1    = (op == OP_LUI) ? '0 : instr[19:15];    // lui adds to zero
    assign o_rs2    = instr[24:20];
    assign o_rd     = instr[11:7];
    assign o_pc     = pc;
    assign o_pc_p4  = pc_p4;
    assign o_funct3 = funct3;

endmodule

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    input  rv_pkg::reg_idx_t i_rd,
    input  rv_pkg::pc_t      i_pc,
    input  rv_pkg::pc_t      i_pc_p4,
    input  rv_pkg::imm_t     i_imm,
    input  logic             i_reg_write,
    input  logic             i_mem_read,
    input  logic             i_mem_write,
    input  rv_pkg::res_src_e i_res_src,
    input  logic             i_jump,
    input  logic             i_branch,
    input  logic             i_alu_src,
    input  logic             i_pc_rel,
    input  logic [2:0]       i_funct3,
    input  rv_pkg::alu_op_e  i_alu_ctrl,
    output logic             o_stall,
    output logic             o_flush,
    output rv_pkg::pc_t      o_redirect_pc,
    output logic             o_lsu_start,
    output logic             o_lsu_we,
    output rv_pkg::pc_t      o_lsu_addr,
    output rv_pkg::word_t    o_lsu_wdata,
    input  logic             i_lsu_done,
    input  rv_pkg::word_t    i_lsu_rdata,
    output logic             o_wb_valid,
    output rv_pkg::reg_idx_t o_wb_rd,
    output rv_pkg::word_t    o_wb_data
);
    import rv_pkg::*;

    word_t regs [1:31];
    word_t rs1_val;
    word_t rs2_val;
    word_t op_a;
    word_t op_b;
    word_t alu_res;
    logic  taken;
    logic  mem_op;
    logic  busy;    // lsu transfer outstanding

    assign rs1_val = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign rs2_val = (i_rs2 == '0) ? '0 : regs[i_rs2];
    assign op_a    = i_pc_rel ? {i_pc, 2'b00} : rs1_val;
    assign op_b    = i_alu_src ? i_imm : rs2_val;

    always_comb
    begin
        case (i_alu_ctrl)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {31'b0, i_funct3[0] ? (op_a < op_b)
                                                   : ($signed(op_a) < $signed(op_b))};
            ALU_SHL: alu_res = op_a << op_b[4:0];
            default: alu_res = op_a >> op_b[4:0];
        endcase
    end

    always_comb
    begin
        case (i_funct3)
            3'b000:  taken = (rs1_val == rs2_val);
            3'b001:  taken = (rs1_val != rs2_val);
            3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  taken = (rs1_val < rs2_val);
            3'b111:  taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign o_flush       = i_jump || (i_branch && taken);
    assign o_redirect_pc = i_branch ? (i_pc + i_imm[31:2]) : alu_res[31:2];

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            busy <= 1'b0;
        else if (i_lsu_done)
            busy <= 1'b0;
        else if (o_lsu_start)
            busy <= 1'b1;
    end

    assign mem_op      = i_mem_read || i_mem_write;
    assign o_lsu_start = mem_op && !busy;
    assign o_stall     = mem_op && !i_lsu_done;
    assign o_lsu_we    = i_mem_write;
    assign o_lsu_addr  = alu_res[31:2];
    assign o_lsu_wdata = rs2_val;

    always_comb
    begin
        case (i_res_src)
            RES_MEM: o_wb_data = i_lsu_rdata;
            RES_PC4: o_wb_data = {i_pc_p4, 2'b00};
            default: o_wb_data = alu_res;
        endcase
    end

    assign o_wb_valid = i_reg_write && (i_rd != '0) && (!i_mem_read || i_lsu_done);
    assign o_wb_rd    = i_rd;

    always_ff @(posedge i_clk)
    begin
        if (o_wb_valid)
            regs[i_rd] <= o_wb_data;
    end

endmodule

// ==== design/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          i_clk,
    input  logic          i_arst_n,
    input  logic          i_run,
    input  logic          i_stall,
    input  logic          i_flush,
    input  rv_pkg::pc_t   i_redirect_pc,
    output logic          o_bus_req,
    input  logic          i_bus_ack,
    output rv_pkg::pc_t   o_bus_addr,
    input  rv_pkg::word_t i_bus_rdata,
    output logic          o_instr_valid,
    output rv_pkg::word_t o_instr,
    output rv_pkg::pc_t   o_pc,
    output rv_pkg::pc_t   o_pc_p4
);
    import rv_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, WAIT_LOW, HOLD} state_e;

    state_e state;
    pc_t    pc;          // next fetch address
    pc_t    bus_addr;    // address of fetch in flight or held
    word_t  instr;
    logic   drop;        // fetch in flight went stale

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state <= IDLE;
            pc    <= RESET_PC[31:2];
            drop  <= 1'b0;
        end
        else
        begin
            if (i_flush)
                pc <= i_redirect_pc;
            case (state)
                IDLE:
                begin
                    drop <= 1'b0;
                    if (i_run && !i_flush)
                    begin
                        pc    <= pc + 1'b1;
                        state <= REQ;
                    end
                end
                REQ:
                begin
                    if (i_flush)
                        drop <= 1'b1;
                    if (i_bus_ack)
                        state <= WAIT_LOW;
                end
                WAIT_LOW:
                begin
                    if (i_flush)
                        drop <= 1'b1;
                    if (!i_bus_ack)
                        state <= (drop || i_flush) ? IDLE : HOLD;
                end
                HOLD:
                    if (i_flush || !i_stall)
                        state <= IDLE;    // taken by decode, or dropped
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (state == IDLE)
            bus_addr <= pc;
        if ((state == REQ) && i_bus_ack)
            instr <= i_bus_rdata;
    end

    assign o_bus_req     = (state == REQ);
    assign o_bus_addr    = bus_addr;
    assign o_instr_valid = (state == HOLD);
    assign o_instr       = instr;
    assign o_pc          = bus_addr;
    assign o_pc_p4       = bus_addr + 1'b1;

endmodule

// ==== design/rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu (
    input  logic          i_clk,
    input  logic          i_arst_n,
    input  logic          i_start,
    input  logic          i_we,
    input  rv_pkg::pc_t   i_addr,
    input  rv_pkg::word_t i_wdata,
    output logic          o_done,
    output rv_pkg::word_t o_rdata,
    output logic          o_bus_req,
    output logic          o_bus_we,
    output rv_pkg::pc_t   o_bus_addr,
    output rv_pkg::word_t o_bus_wdata,
    input  logic          i_bus_ack,
    input  rv_pkg::word_t i_bus_rdata
);
    import rv_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, WAIT_LOW} state_e;

    state_e state;
    logic   we;
    pc_t    addr;
    word_t  wdata;
    word_t  rdata;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:     if (i_start) state <= REQ;
                REQ:      if (i_bus_ack) state <= WAIT_LOW;
                WAIT_LOW: if (!i_bus_ack) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if ((state == IDLE) && i_start)
        begin
            we    <= i_we;
            addr  <= i_addr;
            wdata <= i_wdata;
        end
        if ((state == REQ) && i_bus_ack)
            rdata <= i_bus_rdata;
    end

    assign o_bus_req   = (state == REQ);
    assign o_bus_we    = we;
    assign o_bus_addr  = addr;
    assign o_bus_wdata = wdata;
    assign o_done      = (state == WAIT_LOW) && !i_bus_ack;    // handshake closed
    assign o_rdata     = rdata;

endmodule

// ==== design/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [29:0] pc_t;     // pc bits 31..2
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] imm_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SLT = 3'b101,    // funct3[0] picks unsigned
        ALU_SHL = 3'b110,
        ALU_SHR = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } res_src_e;

    localparam logic [6:0] OP_LOAD   = 7'h03;
    localparam logic [6:0] OP_IMM    = 7'h13;
    localparam logic [6:0] OP_AUIPC  = 7'h17;
    localparam logic [6:0] OP_STORE  = 7'h23;
    localparam logic [6:0] OP_REG    = 7'h33;
    localparam logic [6:0] OP_LUI    = 7'h37;
    localparam logic [6:0] OP_BRANCH = 7'h63;
    localparam logic [6:0] OP_JALR   = 7'h67;
    localparam logic [6:0] OP_JAL    = 7'h6F;

endpackage

// ==== design/rv_ram.sv ====
`timescale 1ns/1ps

module rv_ram #(
    parameter int MEM_DEPTH = 256
) (
    input  logic          i_clk,
    input  logic          i_arst_n,
    input  logic          i_req,
    input  logic          i_we,
    input  rv_pkg::pc_t   i_addr,
    input  rv_pkg::word_t i_wdata,
    output logic          o_ack,
    output rv_pkg::word_t o_rdata,
    input  logic          i_ld_we,
    input  rv_pkg::pc_t   i_ld_addr,
    input  rv_pkg::word_t i_ld_data
);
    import rv_pkg::*;

    localparam int AW = $clog2(MEM_DEPTH);

    word_t         mem [MEM_DEPTH];
    logic [AW-1:0] idx;
    logic [AW-1:0] ld_idx;

    assign idx    = i_addr[AW-1:0];
    assign ld_idx = i_ld_addr[AW-1:0];

    // ack trails req by one cycle, on both edges
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_ack <= 1'b0;
        else
            o_ack <= i_req;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_ld_we)
            mem[ld_idx] <= i_ld_data;
        else if (i_req && !o_ack && i_we)
            mem[idx] <= i_wdata;
        if (i_req && !o_ack)
            o_rdata <= mem[idx];
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -Wno-fatal -f vlog.f --top-module tb_rv_core -o tb_rv_core
./obj_dir/tb_rv_core 2>&1 | tee sim.log
if grep -q "TESTS FAILED" sim.log
then
    echo "simulation reported a failure"
    exit 1
fi
grep -q "TESTS PASSED" sim.log

// ==== test/rv_core_chk.sv ====
`timescale 1ns/1ps

module rv_core_chk (
    input logic i_clk,
    input logic i_arst_n,
    input logic i_f_req,
    input logic i_f_ack,
    input logic i_d_req,
    input logic i_d_ack,
    input logic i_m_req,
    input logic i_m_ack
);

    // ram ack belongs to exactly one granted master
    one_grant: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_m_ack |-> (i_f_ack ^ i_d_ack))
        else $error("ram ack not routed to exactly one master");

    // ack only answers a live request
    ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(i_m_ack) |-> i_m_req)
        else $error("ram ack rose without a request");

    f_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(i_f_ack) |-> i_f_req)
        else $error("fetch ack rose without a fetch request");

    d_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(i_d_ack) |-> i_d_req)
        else $error("lsu ack rose without an lsu request");

    f_req_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_f_req && !i_f_ack) |=> i_f_req)
        else $error("fetch request dropped before ack");

    d_req_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_d_req && !i_d_ack) |=> i_d_req)
        else $error("lsu request dropped before ack");

endmodule

bind rv_core_top rv_core_chk u_chk (
    .i_clk   (i_clk),
    .i_arst_n(i_arst_n),
    .i_f_req (f_req),
    .i_f_ack (f_ack),
    .i_d_req (l_req),
    .i_d_ack (l_ack),
    .i_m_req (m_req),
    .i_m_ack (m_ack)
);

// ==== test/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam logic [6:0] OPC_LUI   = 7'h37;
    localparam logic [6:0] OPC_AUIPC = 7'h17;
    localparam logic [6:0] OPC_IMM   = 7'h13;
    localparam logic [6:0] OPC_LOAD  = 7'h03;
    localparam logic [6:0] OPC_JALR  = 7'h67;

    // funct3, rs1, rs2 and taken, with x3 = 5 and x4 = -3
    localparam logic [2:0] BR_F3 [12] = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4,
                                          3'd5, 3'd5, 3'd6, 3'd6, 3'd7, 3'd7};
    localparam logic [4:0] BR_RS1 [12] = '{5'd3, 5'd3, 5'd3, 5'd3, 5'd4, 5'd3,
                                           5'd3, 5'd4, 5'd3, 5'd4, 5'd4, 5'd3};
    localparam logic [4:0] BR_RS2 [12] = '{5'd3, 5'd4, 5'd4, 5'd3, 5'd3, 5'd4,
                                           5'd4, 5'd3, 5'd4, 5'd3, 5'd3, 5'd4};
    localparam bit BR_TAKEN [12] = '{1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0};

    logic     i_clk;
    logic     i_arst_n;
    logic     i_run;
    logic     i_ld_we;
    pc_t      i_ld_addr;
    word_t    i_ld_data;
    logic     o_wb_valid;
    reg_idx_t o_wb_rd;
    word_t    o_wb_data;

    word_t    prog [$];
    string    exp_name [$];
    reg_idx_t exp_rd [$];
    word_t    exp_val [$];
    int       cycles = 0;
    int       cycle_limit = 0;
    int       seen = 0;
    bit       passed = 1'b0;
    bit       fail_shown = 1'b0;

    rv_core_top #(.MEM_DEPTH(256), .RESET_PC(32'h0)) DUT (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_run(i_run),
        .i_ld_we(i_ld_we), .i_ld_addr(i_ld_addr), .i_ld_data(i_ld_data),
        .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data)
    );

    always #4 i_clk = ~i_clk;

    function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic word_t j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic emit_marker();
        emit(i_type(12'h5a5, 5'd0, 3'b000, 5'd31, OPC_IMM));    // must be skipped
    endtask

    task automatic expect_wb(input string name, input reg_idx_t rd, input word_t val);
        exp_name.push_back(name);
        exp_rd.push_back(rd);
        exp_val.push_back(val);
    endtask

    task automatic build_program();
        word_t ra;
        word_t rb;
        word_t a;
        word_t b;
        word_t pc;
        ra = $urandom();
        rb = $urandom();
        a  = {ra[31:12], 12'h000} + {{20{ra[11]}}, ra[11:0]};
        b  = {rb[31:12], 12'h000} + {{20{rb[11]}}, rb[11:0]};
        emit(u_type(ra[31:12], 5'd1, OPC_LUI));
        expect_wb("lui_a", 5'd1, {ra[31:12], 12'h000});
        emit(i_type(ra[11:0], 5'd1, 3'b000, 5'd1, OPC_IMM));
        expect_wb("addi_a", 5'd1, a);
        emit(u_type(rb[31:12], 5'd2, OPC_LUI));
        expect_wb("lui_b", 5'd2, {rb[31:12], 12'h000});
        emit(i_type(rb[11:0], 5'd2, 3'b000, 5'd2, OPC_IMM));
        expect_wb("addi_b", 5'd2, b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
        expect_wb("add", 5'd5, a + b);
        emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd6));
        expect_wb("sub", 5'd6, a - b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd7));
        expect_wb("and", 5'd7, a & b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd8));
        expect_wb("or", 5'd8, a | b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd9));
        expect_wb("xor", 5'd9, a ^ b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd10));
        expect_wb("slt", 5'd10, {31'b0, $signed(a) < $signed(b)});
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd11));
        expect_wb("sltu", 5'd11, {31'b0, a < b});
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd3, OPC_IMM));
        expect_wb("addi_five", 5'd3, 32'd5);
        emit(r_type(7'h00, 5'd3, 5'd1, 3'b001, 5'd12));
        expect_wb("sll", 5'd12, a << 5);
        emit(r_type(7'h00, 5'd3, 5'd1, 3'b101, 5'd13));
        expect_wb("srl", 5'd13, a >> 5);
        pc = word_t'(prog.size() * 4);
        emit(u_type(20'h12345, 5'd14, OPC_AUIPC));
        expect_wb("auipc", 5'd14, pc + 32'h1234_5000);
        emit(i_type(12'hffd, 5'd0, 3'b000, 5'd4, OPC_IMM));
        expect_wb("addi_neg", 5'd4, 32'hffff_fffd);
        for (int k = 0; k < 12; k++)
        begin
            emit(b_type(13'd8, BR_RS2[k], BR_RS1[k], BR_F3[k]));
            if (BR_TAKEN[k])
                emit_marker();
            else
            begin
                emit(i_type(12'(16 + k), 5'd0, 3'b000, 5'd15, OPC_IMM));
                expect_wb($sformatf("branch%0d_not_taken", k), 5'd15, 32'(16 + k));
            end
        end
        pc = word_t'(prog.size() * 4);
        emit(j_type(21'd8, 5'd18));
        expect_wb("jal_link", 5'd18, pc + 32'd4);
        emit_marker();
        pc = word_t'(prog.size() * 4);
        emit(u_type(20'h0, 5'd19, OPC_AUIPC));
        expect_wb("auipc_base", 5'd19, pc);
        emit(i_type(12'd16, 5'd19, 3'b000, 5'd20, OPC_JALR));    // lands at base + 16
        expect_wb("jalr_link", 5'd20, pc + 32'd8);
        emit_marker();
        emit_marker();
        emit(s_type(12'h200, 5'd2, 5'd0));
        emit(s_type(12'h204, 5'd1, 5'd0));
        emit(i_type(12'h200, 5'd0, 3'b010, 5'd21, OPC_LOAD));
        expect_wb("lw_b", 5'd21, b);
        emit(i_type(12'h204, 5'd0, 3'b010, 5'd22, OPC_LOAD));
        expect_wb("lw_a", 5'd22, a);
        emit(i_type(12'd123, 5'd0, 3'b000, 5'd0, OPC_IMM));     // x0 stays zero
        emit(i_type(12'h204, 5'd0, 3'b010, 5'd0, OPC_LOAD));
        emit(i_type(12'd7, 5'd0, 3'b000, 5'd23, OPC_IMM));
        expect_wb("read_x0", 5'd23, 32'd7);
        emit(j_type(21'd0, 5'd0));    // park here
    endtask

    task automatic stop_with_failure();
        fail_shown = 1'b1;
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge i_clk)
    begin
        if (i_run)
        begin
            cycles = cycles + 1;
            assert (cycles < cycle_limit)
            else
            begin
                $display("run timed out after %0d cycles with %0d of %0d writebacks seen",
                         cycles, seen, exp_rd.size());
                stop_with_failure();
            end
        end
    end

    initial
    begin
        i_clk     = 1'b0;
        i_arst_n  = 1'b0;
        i_run     = 1'b0;
        i_ld_we   = 1'b0;
        i_ld_addr = '0;
        i_ld_data = '0;
        void'($urandom(32'h81d593c5));
        build_program();
        cycle_limit = 40 * prog.size();
        repeat (8) @(negedge i_clk);
        i_arst_n = 1'b1;
        for (int i = 0; i < prog.size(); i++)
        begin
            @(negedge i_clk);
            i_ld_we   = 1'b1;
            i_ld_addr = pc_t'(i);
            i_ld_data = prog[i];
        end
        @(negedge i_clk);
        i_ld_we = 1'b0;
        i_run   = 1'b1;
        for (int i = 0; i < exp_rd.size(); i++)
        begin
            @(negedge i_clk);
            while (!o_wb_valid)
                @(negedge i_clk);
            assert ((o_wb_rd == exp_rd[i]) && (o_wb_data == exp_val[i]))
            else
            begin
                $display("[FAIL] %s expected x%0d=%08h actual x%0d=%08h",
                         exp_name[i], exp_rd[i], exp_val[i], o_wb_rd, o_wb_data);
                stop_with_failure();
            end
            seen = i + 1;
        end
        repeat (48)    // parked loop, nothing more retires
        begin
            @(negedge i_clk);
            assert (!o_wb_valid)
            else
            begin
                $display("unexpected writeback to x%0d after the last expected one", o_wb_rd);
                stop_with_failure();
            end
        end
        passed = 1'b1;
        $display("TESTS PASSED");
        $finish;
    end

    final
    begin
        if (!passed && !fail_shown)
            $display("TESTS FAILED");
    end

endmodule

// ==== vlog.f ====
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_lsu.sv
design/rv_bus_arbiter.sv
design/rv_ram.sv
design/rv_core_top.sv
test/rv_core_chk.sv
test/tb_rv_core.sv
